// File: alioth_params.svh
`ifndef ALIOTH_PARAMS_SVH
`define ALIOTH_PARAMS_SVH

// datapath widths
`define XLEN            32
`define REG_ADDR_WIDTH  5
`define INST_WIDTH      32

// rv32i major opcodes still decoded
`define OPC_OP          7'b0110011
`define OPC_OP_IMM      7'b0010011
`define OPC_LUI         7'b0110111
`define OPC_LOAD        7'b0000011
`define OPC_STORE       7'b0100011

// peripheral address map
`define LED_ADDR        32'h8000_0000
`define SW_LO_ADDR      32'h8000_0010  // switch bits 31:0
`define SW_HI_ADDR      32'h8000_0014  // switch bits 63:32
`define SW_WIDTH        64

`endif

// File: alioth_pkg.sv
`include "alioth_params.svh"

package alioth_pkg;

    // alu operation select
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10  // lui, operand b straight through
    } alu_op_e;

    // one decoded instruction, idu -> exu
    typedef struct packed {
        logic                       valid;
        alu_op_e                    alu_op;
        logic                       use_imm;   // operand b from imm instead of rs2
        logic [`XLEN-1:0]           imm;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [`REG_ADDR_WIDTH-1:0] rs2;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic                       reg_we;
        logic                       is_load;
        logic                       is_store;
    } dec_info_t;

    // register writeback, also the top level commit port
    typedef struct packed {
        logic                       valid;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`XLEN-1:0]           data;
    } commit_t;

    // word access towards the peripherals
    typedef struct packed {
        logic             rd_en;
        logic             wr_en;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] wdata;
    } mem_req_t;

endpackage

// File: idu.sv
`include "alioth_params.svh"

module idu import alioth_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic                   inst_valid_i,
    input  logic [`INST_WIDTH-1:0] inst_i,
    output dec_info_t              dec_o
);

    logic [6:0]                 opcode;
    logic [2:0]                 funct3;
    logic [6:0]                 funct7;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic [`REG_ADDR_WIDTH-1:0] rs1;
    logic [`REG_ADDR_WIDTH-1:0] rs2;
    logic [`XLEN-1:0]           imm_i;
    logic [`XLEN-1:0]           imm_s;
    logic [`XLEN-1:0]           imm_u;
    logic                       alt;       // funct7 bit 5, sub / sra
    logic                       op_legal;
    logic                       op_imm_legal;
    alu_op_e                    alu_op;
    dec_info_t                  dec_d;

    assign opcode = inst_i[6:0];
    assign rd     = inst_i[11:7];
    assign funct3 = inst_i[14:12];
    assign rs1    = inst_i[19:15];
    assign rs2    = inst_i[24:20];
    assign funct7 = inst_i[31:25];
    assign alt    = funct7[5];

    // sign extended immediates
    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_u = {inst_i[31:12], 12'b0};

    // reg-reg: funct7 is zero, or 0100000 for sub and sra only
    assign op_legal = (funct7 == 7'b0000000) ||
                      (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

    // shift immediates carry funct7 in the upper imm bits
    always_comb begin
        case (funct3)
            3'b001:  op_imm_legal = (funct7 == 7'b0000000);
            3'b101:  op_imm_legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
            default: op_imm_legal = 1'b1;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  alu_op = (opcode == `OPC_OP && alt) ? ALU_SUB : ALU_ADD;  // no subi
            3'b001:  alu_op = ALU_SLL;
            3'b010:  alu_op = ALU_SLT;
            3'b011:  alu_op = ALU_SLTU;
            3'b100:  alu_op = ALU_XOR;
            3'b101:  alu_op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase
    end

    always_comb begin
        dec_d     = '0;
        dec_d.rs1 = rs1;
        dec_d.rd  = rd;
        case (opcode)
            `OPC_OP: begin
                dec_d.valid  = op_legal;
                dec_d.alu_op = alu_op;
                dec_d.rs2    = rs2;
                dec_d.reg_we = 1'b1;
            end
            `OPC_OP_IMM: begin
                dec_d.valid   = op_imm_legal;
                dec_d.alu_op  = alu_op;
                dec_d.use_imm = 1'b1;
                dec_d.imm     = imm_i;   // shifts only look at the low 5 bits
                dec_d.reg_we  = 1'b1;
            end
            `OPC_LUI: begin
                dec_d.valid   = 1'b1;
                dec_d.alu_op  = ALU_PASS_B;
                dec_d.use_imm = 1'b1;
                dec_d.imm     = imm_u;
                dec_d.rs1     = '0;
                dec_d.reg_we  = 1'b1;
            end
            `OPC_LOAD: begin
                dec_d.valid   = (funct3 == 3'b010);  // lw only
                dec_d.alu_op  = ALU_ADD;
                dec_d.use_imm = 1'b1;
                dec_d.imm     = imm_i;
                dec_d.reg_we  = 1'b1;
                dec_d.is_load = 1'b1;
            end
            `OPC_STORE: begin
                dec_d.valid    = (funct3 == 3'b010);  // sw only
                dec_d.alu_op   = ALU_ADD;
                dec_d.use_imm  = 1'b1;
                dec_d.imm      = imm_s;
                dec_d.rs2      = rs2;
                dec_d.is_store = 1'b1;
            end
            default: ;  // unsupported, stays invalid
        endcase
        dec_d.valid    = dec_d.valid & inst_valid_i;
        dec_d.reg_we   = dec_d.reg_we & dec_d.valid & (rd != '0);  // x0 never written
        dec_d.is_load  = dec_d.is_load & dec_d.valid;
        dec_d.is_store = dec_d.is_store & dec_d.valid;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dec_o <= '0;
        end else begin
            dec_o <= dec_d;
        end
    end

endmodule

// File: gpr.sv
`include "alioth_params.svh"

module gpr import alioth_pkg::*; (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  logic [`REG_ADDR_WIDTH-1:0] raddr1_i,
    input  logic [`REG_ADDR_WIDTH-1:0] raddr2_i,
    output logic [`XLEN-1:0]           rdata1_o,
    output logic [`XLEN-1:0]           rdata2_o,
    input  commit_t                    wr_i
);

    // x1..x31, x0 has no storage
    logic [`XLEN-1:0] regs [1:31];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.valid && wr_i.rd != '0) begin
            regs[wr_i.rd] <= wr_i.data;
        end
    end

    // combinational reads, forwarding of the same-cycle write is done in exu
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// File: exu.sv
`include "alioth_params.svh"

module exu import alioth_pkg::*; (
    input  logic             clk,
    input  logic             arst_n_i,
    input  dec_info_t        dec_i,
    input  logic [`XLEN-1:0] rdata1_i,
    input  logic [`XLEN-1:0] rdata2_i,
    output mem_req_t         mem_req_o,
    input  logic [`XLEN-1:0] mem_rdata_i,
    output commit_t          commit_o
);

    commit_t                    commit_q;
    logic                       fwd1;
    logic                       fwd2;
    logic [`XLEN-1:0]           op1;
    logic [`XLEN-1:0]           op2;       // rs2 value, also store data
    logic [`XLEN-1:0]           op_b;
    logic [$clog2(`XLEN)-1:0]   shamt;
    logic [`XLEN-1:0]           alu_res;

    // bypass from the commit register
    // gpr holds the value one cycle later, so nothing older is needed
    assign fwd1 = commit_q.valid && (commit_q.rd != '0) && (commit_q.rd == dec_i.rs1);
    assign fwd2 = commit_q.valid && (commit_q.rd != '0) && (commit_q.rd == dec_i.rs2);

    assign op1   = fwd1 ? commit_q.data : rdata1_i;
    assign op2   = fwd2 ? commit_q.data : rdata2_i;
    assign op_b  = dec_i.use_imm ? dec_i.imm : op2;
    assign shamt = op_b[$clog2(`XLEN)-1:0];

    always_comb begin
        case (dec_i.alu_op)
            ALU_ADD:    alu_res = op1 + op_b;
            ALU_SUB:    alu_res = op1 - op_b;
            ALU_SLL:    alu_res = op1 << shamt;
            ALU_SLT:    alu_res = {{(`XLEN-1){1'b0}}, $signed(op1) < $signed(op_b)};
            ALU_SLTU:   alu_res = {{(`XLEN-1){1'b0}}, op1 < op_b};
            ALU_XOR:    alu_res = op1 ^ op_b;
            ALU_SRL:    alu_res = op1 >> shamt;
            ALU_SRA:    alu_res = $unsigned($signed(op1) >>> shamt);
            ALU_OR:     alu_res = op1 | op_b;
            ALU_AND:    alu_res = op1 & op_b;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    // loads and stores decode as add with the offset, so alu_res is rs1 + imm
    always_comb begin
        mem_req_o.rd_en = dec_i.valid & dec_i.is_load;
        mem_req_o.wr_en = dec_i.valid & dec_i.is_store;
        mem_req_o.addr  = alu_res;
        mem_req_o.wdata = op2;
    end

    // commit stage, load word arrives in this same cycle
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            commit_q <= '0;
        end else begin
            commit_q.valid <= dec_i.valid & dec_i.reg_we;
            commit_q.rd    <= dec_i.rd;
            commit_q.data  <= dec_i.is_load ? mem_rdata_i : alu_res;
        end
    end

    assign commit_o = commit_q;

endmodule

// File: periph.sv
`include "alioth_params.svh"

module periph import alioth_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  mem_req_t             req_i,
    output logic [`XLEN-1:0]     rdata_o,
    input  logic [`SW_WIDTH-1:0] virtual_sw_i,
    output logic [`XLEN-1:0]     led_o
);

    logic [`XLEN-1:0] led_q;

    // led register, other store addresses are dropped
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            led_q <= '0;
        end else if (req_i.wr_en && req_i.addr == `LED_ADDR) begin
            led_q <= req_i.wdata;
        end
    end

    assign led_o = led_q;

    // switch words, unmapped loads read zero
    always_comb begin
        rdata_o = '0;
        if (req_i.rd_en) begin
            case (req_i.addr)
                `SW_LO_ADDR: rdata_o = virtual_sw_i[`XLEN-1:0];
                `SW_HI_ADDR: rdata_o = virtual_sw_i[`SW_WIDTH-1:`XLEN];
                default:     rdata_o = '0;
            endcase
        end
    end

endmodule

// File: alioth_top.sv
`include "alioth_params.svh"

module alioth_top import alioth_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic                   inst_valid_i,
    input  logic [`INST_WIDTH-1:0] inst_i,
    input  logic [`SW_WIDTH-1:0]   virtual_sw_i,  // 64 virtual switches
    output logic [`XLEN-1:0]       led_o,
    output commit_t                commit_o
);

    dec_info_t        idu_dec;
    logic [`XLEN-1:0] gpr_rdata1;
    logic [`XLEN-1:0] gpr_rdata2;
    mem_req_t         exu_mem_req;
    logic [`XLEN-1:0] periph_rdata;
    commit_t          exu_commit;   // writeback and external commit

    idu u_idu (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .inst_valid_i(inst_valid_i),
        .inst_i      (inst_i),
        .dec_o       (idu_dec)
    );

    gpr u_gpr (
        .clk     (clk),
        .arst_n_i(arst_n_i),
        .raddr1_i(idu_dec.rs1),
        .raddr2_i(idu_dec.rs2),
        .rdata1_o(gpr_rdata1),
        .rdata2_o(gpr_rdata2),
        .wr_i    (exu_commit)
    );

    exu u_exu (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .dec_i      (idu_dec),
        .rdata1_i   (gpr_rdata1),
        .rdata2_i   (gpr_rdata2),
        .mem_req_o  (exu_mem_req),
        .mem_rdata_i(periph_rdata),
        .commit_o   (exu_commit)
    );

    periph u_periph (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .req_i       (exu_mem_req),
        .rdata_o     (periph_rdata),
        .virtual_sw_i(virtual_sw_i),
        .led_o       (led_o)
    );

    assign commit_o = exu_commit;

endmodule

// File: tb_alioth_top.sv
`include "alioth_params.svh"

module tb_alioth_top import alioth_pkg::*; ();

    localparam int MAX_ROWS = 64;

    // stimulus and the expectation checked in one table row
    typedef struct packed {
        logic [`INST_WIDTH-1:0] inst;
        logic                   vld;
        logic [`SW_WIDTH-1:0]   sw;
        logic                   exp_valid;
        logic [4:0]             exp_rd;
        logic [`XLEN-1:0]       exp_data;
        logic [`XLEN-1:0]       exp_led;
    } row_t;

    logic                   clk = 1'b0;
    logic                   arst_n_i;
    logic                   inst_valid_i;
    logic [`INST_WIDTH-1:0] inst_i;
    logic [`SW_WIDTH-1:0]   virtual_sw_i;
    logic [`XLEN-1:0]       led_o;
    commit_t                commit_o;

    row_t                   rows [0:MAX_ROWS-1];
    string                  row_name [0:MAX_ROWS-1];
    int                     n_built = 0;
    int                     n_rows = 0;
    int                     errors = 0;
    int                     failed_rows = 0;
    int                     cycle_cnt = 0;
    int                     max_cycles = 1000;  // replaced once the table is built
    int                     seed = 34538;
    logic [`XLEN-1:0]       led_model = '0;
    logic [`SW_WIDTH-1:0]   sw_model = '0;

    alioth_top alioth_top_i (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .inst_valid_i(inst_valid_i),
        .inst_i      (inst_i),
        .virtual_sw_i(virtual_sw_i),
        .led_o       (led_o),
        .commit_o    (commit_o)
    );

    always #50 clk = ~clk;

    // rv32i encoders
    function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
                                          input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], `OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3,
                                          input int rd, input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] enc_s(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], `OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_u(input int imm20, input int rd);
        return {imm20[19:0], rd[4:0], `OPC_LUI};
    endfunction

    // result of this row's stimulus is expected two rows on
    task automatic add_row(input string name, input logic [31:0] inst, input logic vld,
                           input logic cv, input int crd, input logic [31:0] cdata);
        rows[n_built].inst        = inst;
        rows[n_built].vld         = vld;
        rows[n_built].sw          = sw_model;
        rows[n_built+2].exp_valid = cv;
        rows[n_built+2].exp_rd    = crd[4:0];
        rows[n_built+2].exp_data  = cdata;
        rows[n_built+2].exp_led   = led_model;
        row_name[n_built+2]       = name;
        n_built++;
    endtask

    task automatic issue_wr(input string name, input logic [31:0] inst, input int rd,
                            input logic [31:0] data);
        add_row(name, inst, 1'b1, 1'b1, rd, data);
    endtask

    task automatic issue_quiet(input string name, input logic [31:0] inst);
        add_row(name, inst, 1'b1, 1'b0, 0, 32'h0);
    endtask

    task automatic idle_row(input string name);
        add_row(name, 32'h0, 1'b0, 1'b0, 0, 32'h0);
    endtask

    task automatic build_table();
        for (int i = 0; i < MAX_ROWS; i++) begin
            rows[i]     = '0;
            row_name[i] = "after reset";
        end
        idle_row("idle");
        add_row("strobe low ignored", enc_i(1, 0, 0, 28, `OPC_OP_IMM), 1'b0, 1'b0, 0, 32'h0);

        // x1 = -5 and x2 = 100 from the immediate ops feed most of the rest
        issue_wr("addi -5", enc_i(-5, 0, 0, 1, `OPC_OP_IMM), 1, 32'hFFFF_FFFB);
        issue_wr("addi 100", enc_i(100, 0, 0, 2, `OPC_OP_IMM), 2, 32'h0000_0064);
        issue_wr("addi -2048", enc_i(-2048, 1, 0, 3, `OPC_OP_IMM), 3, 32'hFFFF_F7FB);
        issue_wr("slti", enc_i(3, 1, 2, 4, `OPC_OP_IMM), 4, 32'h1);  // signed -5 < 3
        issue_wr("sltiu true", enc_i(101, 2, 3, 5, `OPC_OP_IMM), 5, 32'h1);
        issue_wr("sltiu false", enc_i(5, 1, 3, 6, `OPC_OP_IMM), 6, 32'h0);
        issue_wr("xori", enc_i(-1, 2, 4, 7, `OPC_OP_IMM), 7, 32'hFFFF_FF9B);
        issue_wr("ori", enc_i(32'h70F, 2, 6, 8, `OPC_OP_IMM), 8, 32'h0000_076F);
        issue_wr("andi", enc_i(32'h0F0, 1, 7, 9, `OPC_OP_IMM), 9, 32'h0000_00F0);
        issue_wr("slli", enc_i(20, 2, 1, 10, `OPC_OP_IMM), 10, 32'h0640_0000);
        issue_wr("srli", enc_i(4, 1, 5, 11, `OPC_OP_IMM), 11, 32'h0FFF_FFFF);
        issue_wr("srai", enc_i(32'h404, 1, 5, 12, `OPC_OP_IMM), 12, 32'hFFFF_FFFF);
        issue_wr("lui", enc_u(32'hDEADB, 13), 13, 32'hDEAD_B000);
        issue_wr("addi after lui", enc_i(-273, 13, 0, 14, `OPC_OP_IMM), 14, 32'hDEAD_AEEF);

        // register ops mostly read the result just committed
        issue_wr("add", enc_r(0, 2, 2, 0, 15), 15, 32'h0000_00C8);
        issue_wr("sub", enc_r(32, 1, 15, 0, 16), 16, 32'h0000_00CD);
        issue_wr("sll", enc_r(0, 2, 16, 1, 17), 17, 32'h0000_0CD0);
        issue_wr("slt", enc_r(0, 17, 1, 2, 18), 18, 32'h1);
        issue_wr("sltu", enc_r(0, 18, 1, 3, 19), 19, 32'h0);
        issue_wr("xor", enc_r(0, 13, 17, 4, 20), 20, 32'hDEAD_BCD0);
        issue_wr("srl", enc_r(0, 2, 20, 5, 21), 21, 32'h0DEA_DBCD);
        issue_wr("sra", enc_r(32, 2, 20, 5, 22), 22, 32'hFDEA_DBCD);
        issue_wr("or", enc_r(0, 10, 22, 6, 23), 23, 32'hFFEA_DBCD);
        issue_wr("and", enc_r(0, 1, 23, 7, 24), 24, 32'hFFEA_DBC9);
        issue_wr("add both forwarded", enc_r(0, 24, 24, 0, 25), 25, 32'hFFD5_B792);

        // x0 and opcodes the core does not take
        issue_quiet("addi to x0", enc_i(7, 1, 0, 0, `OPC_OP_IMM));
        issue_wr("read x0", enc_i(32'h123, 0, 0, 26, `OPC_OP_IMM), 26, 32'h0000_0123);
        issue_quiet("jal dropped", 32'h0080_02EF);  // jal x5, +8
        issue_quiet("beq dropped", 32'h0020_8863);  // beq x1, x2, +16
        issue_quiet("mul dropped", enc_r(1, 2, 1, 0, 5));
        issue_wr("x5 kept", enc_r(0, 0, 5, 0, 27), 27, 32'h1);

        // only the led address is mapped for stores
        issue_wr("lui led base", enc_u(32'h80000, 29), 29, 32'h8000_0000);
        led_model = 32'hDEAD_B000;
        issue_quiet("sw led", enc_s(0, 13, 29));
        issue_quiet("sw unmapped", enc_s(4, 26, 29));
        issue_quiet("sw to switch addr", enc_s(16, 26, 29));
        issue_wr("addi store data", enc_i(32'h5A5, 0, 0, 30, `OPC_OP_IMM), 30, 32'h0000_05A5);
        led_model = 32'h0000_05A5;
        issue_quiet("sw led forwarded", enc_s(0, 30, 29));

        // loads from the switches
        sw_model = {$random(seed), $random(seed)};
        issue_wr("lw sw low", enc_i(16, 29, 2, 1, `OPC_LOAD), 1, sw_model[31:0]);
        issue_wr("lw sw high", enc_i(20, 29, 2, 2, `OPC_LOAD), 2, sw_model[63:32]);
        issue_wr("add loaded words", enc_r(0, 2, 1, 0, 3), 3,
                 sw_model[31:0] + sw_model[63:32]);
        issue_wr("lw unmapped", enc_i(32, 29, 2, 4, `OPC_LOAD), 4, 32'h0);
        issue_wr("lw led addr", enc_i(0, 29, 2, 5, `OPC_LOAD), 5, 32'h0);
        issue_quiet("lh dropped", enc_i(16, 29, 1, 6, `OPC_LOAD));

        idle_row("drain");
        idle_row("drain");
        n_rows = n_built;
    endtask

    task automatic drive_row(input int idx);
        inst_valid_i = rows[idx].vld;
        inst_i       = rows[idx].inst;
        virtual_sw_i = rows[idx].sw;
    endtask

    task automatic check_row(input int idx);
        row_t r;
        int   errs_before;
        r = rows[idx];
        errs_before = errors;
        assert (commit_o.valid === r.exp_valid) else begin
            $display("FAILED commit_o.valid expected %h got %h", r.exp_valid, commit_o.valid);
            errors++;
        end
        if (r.exp_valid) begin
            assert (commit_o.rd === r.exp_rd) else begin
                $display("FAILED commit_o.rd expected %h got %h", r.exp_rd, commit_o.rd);
                errors++;
            end
            assert (commit_o.data === r.exp_data) else begin
                $display("FAILED commit_o.data expected %h got %h", r.exp_data, commit_o.data);
                errors++;
            end
        end
        assert (led_o === r.exp_led) else begin
            $display("FAILED led_o expected %h got %h", r.exp_led, led_o);
            errors++;
        end
        if (errors == errs_before) begin
            $display("pass  row %0d  %s", idx, row_name[idx]);
        end else begin
            $display("fail  row %0d  %s", idx, row_name[idx]);
            failed_rows++;
        end
    endtask

    // watchdog
    initial begin
        while (cycle_cnt < max_cycles) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: table still running after %0d cycles", cycle_cnt);
        $display("Test failures found");
        $finish;
    end

    initial begin
        arst_n_i     = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        virtual_sw_i = '0;
        build_table();
        max_cycles = n_rows + 20;
        repeat (10) @(posedge clk);
        #1 arst_n_i = 1'b1;
        for (int j = 0; j < n_rows; j++) begin
            @(posedge clk);
            #1;
            check_row(j);  // registered outputs have settled by now
            drive_row(j);
        end
        $display("%0d rows checked, %0d passed, %0d failed, %0d mismatches",
                 n_rows, n_rows - failed_rows, failed_rows, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+.
alioth_pkg.sv
idu.sv
gpr.sv
exu.sv
periph.sv
alioth_top.sv
tb_alioth_top.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f build.f --top-module tb_alioth_top -Mdir obj_dir
	@out="$$(./obj_dir/Vtb_alioth_top)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
